/* bench/tb_safe_domain.sv */
// Testbench for the pad block with LFSR stimulus, shadow register model, compare tasks and timeout

`timescale 1ns/100ps

module tb_safe_domain;

        localparam int unsigned N_PADS = 8;
        localparam int unsigned IDX_W  = $clog2(N_PADS);
        localparam int unsigned ADR_W  = safe_domain_pkg::WB_ADR_W;
        localparam int unsigned DATA_W = safe_domain_pkg::WB_DATA_W;
        localparam int unsigned CFG_W  = safe_domain_pkg::PAD_CFG_W;

        //**************************************************
        // Test lengths and run limit
        //**************************************************

        localparam int unsigned N_REG_OPS     = 100;
        localparam int unsigned N_ROUTE       = 20;
        localparam int unsigned N_SYNC        = 50;
        // Reset reads, random ops, final readback and three pad programming passes
        localparam int unsigned N_ACCESSES    = N_PADS * 5 + N_REG_OPS;
        localparam int unsigned N_STEPS       = N_ROUTE * 4 + N_SYNC + 2;
        localparam int unsigned TIMEOUT_LIMIT = 4 * (N_ACCESSES * 2 + N_STEPS * 3) + 100;

        localparam logic [31:0] LFSR_SEED = 32'h60ae9b3a;
        localparam logic [31:0] LFSR_TAPS = 32'h80200003;

        logic                           clk = 1'b0;
        logic                           reset;
        logic                           wb_cyc;
        logic                           wb_stb;
        logic                           wb_we;
        logic [ADR_W-1:0]               wb_adr;
        logic [DATA_W-1:0]              wb_dat_w;
        logic [DATA_W-1:0]              wb_dat_r;
        logic                           wb_ack;
        logic [N_PADS-1:0]              gpio_out;
        logic [N_PADS-1:0]              gpio_dir;
        logic [N_PADS-1:0]              gpio_in;
        logic [N_PADS-1:0]              periph_out;
        logic [N_PADS-1:0]              periph_oe;
        logic [N_PADS-1:0]              periph_in;
        logic [N_PADS-1:0]              pad_in;
        logic [N_PADS-1:0]              pad_out;
        logic [N_PADS-1:0]              pad_oe;
        logic [N_PADS-1:0][CFG_W-1:0]   pad_cfg;

        // Model state and bookkeeping
        safe_domain_pkg::pad_reg_u      shadow [N_PADS];
        logic [31:0]                    lfsr_state = LFSR_SEED;
        int unsigned                    pass_count = 0;
        int unsigned                    fail_count = 0;
        int unsigned                    test_fails = 0;
        int unsigned                    cycle_count = 0;

        safe_domain
        #(
                .N_PADS       ( N_PADS     )
        )
        i_dut
        (
                .ref_clk_i    ( clk        ),
                .reset_i      ( reset      ),
                .wb_cyc_i     ( wb_cyc     ),
                .wb_stb_i     ( wb_stb     ),
                .wb_we_i      ( wb_we      ),
                .wb_adr_i     ( wb_adr     ),
                .wb_dat_i     ( wb_dat_w   ),
                .wb_dat_o     ( wb_dat_r   ),
                .wb_ack_o     ( wb_ack     ),
                .gpio_out_i   ( gpio_out   ),
                .gpio_dir_i   ( gpio_dir   ),
                .gpio_in_o    ( gpio_in    ),
                .periph_out_i ( periph_out ),
                .periph_oe_i  ( periph_oe  ),
                .periph_in_o  ( periph_in  ),
                .pad_in_i     ( pad_in     ),
                .pad_out_o    ( pad_out    ),
                .pad_oe_o     ( pad_oe     ),
                .pad_cfg_o    ( pad_cfg    )
        );

        initial
        begin
                forever #10 clk = ~clk;
        end

        // Stop a stuck run
        always @(posedge clk)
        begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= TIMEOUT_LIMIT)
                begin
                        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_LIMIT);
                        $display("*** TEST FAILED ***");
                        $finish;
                end
        end

        //**************************************************
        // Random numbers
        //**************************************************

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                if (s[0])
                begin
                        return (s >> 1) ^ LFSR_TAPS;
                end
                return s >> 1;
        endfunction

        // One LFSR step per bit taken
        function automatic logic [31:0] rand_bits(input int unsigned n);
                logic [31:0] bits;
                bits = '0;
                for (int unsigned i = 0; i < n; i++)
                begin
                        lfsr_state = lfsr_next(lfsr_state);
                        bits = {bits[30:0], lfsr_state[0]};
                end
                return bits;
        endfunction

        //**************************************************
        // Model and compare tasks
        //**************************************************

        task automatic model_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] dat);
                safe_domain_pkg::pad_reg_u w;
                w.raw = dat;
                // Reserved bits are not stored
                w.fields.rsvd = '0;
                if (32'(adr) < N_PADS)
                begin
                        shadow[adr[IDX_W-1:0]] = w;
                end
        endtask

        function automatic logic [DATA_W-1:0] model_read(input logic [ADR_W-1:0] adr);
                logic [DATA_W-1:0] word;
                word = '0;
                if (32'(adr) < N_PADS)
                begin
                        word = shadow[adr[IDX_W-1:0]].raw;
                end
                return word;
        endfunction

        function automatic logic [N_PADS-1:0][CFG_W-1:0] cfg_expect();
                logic [N_PADS-1:0][CFG_W-1:0] cfg;
                for (int p = 0; p < N_PADS; p++)
                begin
                        cfg[p] = shadow[p].fields.cfg;
                end
                return cfg;
        endfunction

        task automatic note_result(input logic ok);
                if (ok)
                begin
                        pass_count++;
                end
                else
                begin
                        fail_count++;
                        test_fails++;
                end
        endtask

        task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                                  input logic [DATA_W-1:0] act);
                if (act !== exp)
                begin
                        $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
                end
                note_result(act === exp);
        endtask

        task automatic check_pads(input string name, input logic [N_PADS-1:0] exp,
                                  input logic [N_PADS-1:0] act);
                if (act !== exp)
                begin
                        $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
                end
                note_result(act === exp);
        endtask

        task automatic check_cfg(input logic [N_PADS-1:0][CFG_W-1:0] exp,
                                 input logic [N_PADS-1:0][CFG_W-1:0] act);
                if (act !== exp)
                begin
                        $display("CHECK FAILED pad_cfg_o expected %h actual %h", exp, act);
                end
                note_result(act === exp);
        endtask

        task automatic end_test(input string name);
                $display("%s: done with %0d failing checks", name, test_fails);
                test_fails = 0;
        endtask

        //**************************************************
        // Bus and pad stimulus
        //**************************************************

        // One Wishbone classic access, returns read data sampled with ack
        task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                                  input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rdata);
                int   waited;
                logic got_ack;
                @(negedge clk);
                wb_cyc   = 1'b1;
                wb_stb   = 1'b1;
                wb_we    = we;
                wb_adr   = adr;
                wb_dat_w = dat;
                got_ack  = 1'b0;
                waited   = 0;
                rdata    = '0;
                while (!got_ack && waited < 2)
                begin
                        @(negedge clk);
                        waited++;
                        if (wb_ack === 1'b1)
                        begin
                                got_ack = 1'b1;
                                rdata   = wb_dat_r;
                        end
                end
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                wb_we  = 1'b0;
                if (!got_ack)
                begin
                        $display("Error: no acknowledge within 2 cycles for address %h", adr);
                        note_result(1'b0);
                end
                else if (we)
                begin
                        model_write(adr, dat);
                end
        endtask

        // Write every pad with random cfg, mode 0 GPIO, 1 peripheral, 2 parked
        task automatic program_pads(input int mode);
                safe_domain_pkg::pad_reg_u w;
                logic [DATA_W-1:0]         rdata;
                for (int p = 0; p < N_PADS; p++)
                begin
                        w.raw = rand_bits(DATA_W);
                        if (mode == 0)
                        begin
                                w.fields.mux = safe_domain_pkg::PAD_GPIO;
                        end
                        else if (mode == 1)
                        begin
                                w.fields.mux = safe_domain_pkg::PAD_ALT;
                        end
                        else
                        begin
                                w.fields.mux = w.raw[0] ? safe_domain_pkg::PAD_OFF_3 :
                                                          safe_domain_pkg::PAD_OFF_2;
                        end
                        bus_access(1'b1, ADR_W'(p), w.raw, rdata);
                        check_cfg(cfg_expect(), pad_cfg);
                end
        endtask

        // Random SoC and pad inputs, routing checked against the selector table
        task automatic route_step();
                logic [31:0]       r;
                logic [N_PADS-1:0] exp_out;
                logic [N_PADS-1:0] exp_oe;
                logic [N_PADS-1:0] exp_pin;
                @(negedge clk);
                r = rand_bits(N_PADS);
                gpio_out = r[N_PADS-1:0];
                r = rand_bits(N_PADS);
                gpio_dir = r[N_PADS-1:0];
                r = rand_bits(N_PADS);
                periph_out = r[N_PADS-1:0];
                r = rand_bits(N_PADS);
                periph_oe = r[N_PADS-1:0];
                r = rand_bits(N_PADS);
                pad_in = r[N_PADS-1:0];
                #5;
                for (int p = 0; p < N_PADS; p++)
                begin
                        exp_out[p] = 1'b0;
                        exp_oe[p]  = 1'b0;
                        exp_pin[p] = 1'b0;
                        case (shadow[p].fields.mux)
                                safe_domain_pkg::PAD_GPIO:
                                begin
                                        exp_out[p] = gpio_out[p];
                                        exp_oe[p]  = gpio_dir[p];
                                end
                                safe_domain_pkg::PAD_ALT:
                                begin
                                        exp_out[p] = periph_out[p];
                                        exp_oe[p]  = periph_oe[p];
                                        exp_pin[p] = pad_in[p];
                                end
                                default:
                                begin
                                        exp_out[p] = 1'b0;
                                end
                        endcase
                end
                check_pads("pad_out_o", exp_out, pad_out);
                check_pads("pad_oe_o", exp_oe, pad_oe);
                check_pads("periph_in_o", exp_pin, periph_in);
        endtask

        // Pad inputs change every cycle, GPIO input lags by two edges
        task automatic sync_test();
                logic [31:0]       r;
                logic [N_PADS-1:0] hist1;
                logic [N_PADS-1:0] hist2;
                // Hold the pads so both stages settle first
                repeat (2) @(negedge clk);
                hist1 = pad_in;
                hist2 = pad_in;
                for (int i = 0; i < N_SYNC; i++)
                begin
                        check_pads("gpio_in_o", hist2, gpio_in);
                        r      = rand_bits(N_PADS);
                        hist2  = hist1;
                        hist1  = r[N_PADS-1:0];
                        pad_in = r[N_PADS-1:0];
                        @(negedge clk);
                end
        endtask

        //**************************************************
        // Test sequence
        //**************************************************

        initial
        begin
                logic [31:0]       r;
                logic [DATA_W-1:0] rdata;
                logic [ADR_W-1:0]  adr;
                logic              we;
                reset      = 1'b1;
                wb_cyc     = 1'b0;
                wb_stb     = 1'b0;
                wb_we      = 1'b0;
                wb_adr     = '0;
                wb_dat_w   = '0;
                gpio_out   = '0;
                gpio_dir   = '0;
                periph_out = '0;
                periph_oe  = '0;
                // Pads held high through reset, the synchronizer must still start at zero
                pad_in     = '1;
                for (int p = 0; p < N_PADS; p++)
                begin
                        shadow[p].raw = '0;
                end
                repeat (5) @(negedge clk);
                reset = 1'b0;

                check_word("wb_dat_o", '0, wb_dat_r);
                check_pads("gpio_in_o", '0, gpio_in);
                check_cfg(cfg_expect(), pad_cfg);
                for (int p = 0; p < N_PADS; p++)
                begin
                        bus_access(1'b0, ADR_W'(p), '0, rdata);
                        check_word("wb_dat_o", model_read(ADR_W'(p)), rdata);
                end
                repeat (N_ROUTE) route_step();
                end_test("Reset state");

                // Top address bit set means out of range with aliasing low bits
                for (int i = 0; i < N_REG_OPS; i++)
                begin
                        r   = rand_bits(1);
                        we  = r[0];
                        r   = rand_bits(ADR_W);
                        adr = r[ADR_W-1] ? r[ADR_W-1:0] : ADR_W'(r[IDX_W-1:0]);
                        r   = rand_bits(DATA_W);
                        bus_access(we, adr, r, rdata);
                        if (!we)
                        begin
                                check_word("wb_dat_o", model_read(adr), rdata);
                        end
                        check_cfg(cfg_expect(), pad_cfg);
                end
                for (int p = 0; p < N_PADS; p++)
                begin
                        bus_access(1'b0, ADR_W'(p), '0, rdata);
                        check_word("wb_dat_o", model_read(ADR_W'(p)), rdata);
                end
                end_test("Register access");

                program_pads(0);
                repeat (N_ROUTE) route_step();
                end_test("GPIO routing");

                program_pads(1);
                repeat (N_ROUTE) route_step();
                end_test("Peripheral routing");

                program_pads(2);
                repeat (N_ROUTE) route_step();
                end_test("Parked pads");

                sync_test();
                end_test("GPIO input sync");

                $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
                if (fail_count == 0)
                begin
                        $display("*** TEST PASSED ***");
                end
                else
                begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

endmodule

/* common/safe_domain_pkg.sv */
// Bus widths, pad config width, pad mux selector encoding and pad register word layout

package safe_domain_pkg;

        //**************************************************
        // Bus widths
        //**************************************************

        // Wishbone data word
        localparam int unsigned WB_DATA_W  = 32;

        // Word address, register index equals address
        localparam int unsigned WB_ADR_W   = 8;

        //**************************************************
        // Pad register layout
        //**************************************************

        // Electrical config handed to the pad frame
        // (drive strength, pull up, pull down and similar)
        localparam int unsigned PAD_CFG_W  = 6;

        // Upper bits of the pad word that hold nothing
        localparam int unsigned PAD_RSVD_W = WB_DATA_W - PAD_CFG_W - 2;

        // What drives a pad
        typedef enum logic [1:0] {
                // GPIO bit owns the pad
                PAD_GPIO  = 2'd0,
                // Peripheral function of this pad
                PAD_ALT   = 2'd1,
                // Reserved codes, pad is parked
                PAD_OFF_2 = 2'd2,
                PAD_OFF_3 = 2'd3
        } pad_mux_e;

        // One pad register, seen as a bus word or as its fields
        typedef union packed {
                // Raw Wishbone data word
                logic [WB_DATA_W-1:0] raw;

                // Decoded view, top bits first
                struct packed {
                        logic [PAD_RSVD_W-1:0] rsvd;
                        logic [PAD_CFG_W-1:0]  cfg;
                        pad_mux_e              mux;
                } fields;
        } pad_reg_u;

endpackage

/* hdl/safe_domain.sv */
// Always-on pad block top level with pad config registers and pad mux

`timescale 1ns/100ps

module safe_domain
        #(
                parameter int unsigned N_PADS = 8
        )
        (
                input  logic                                     ref_clk_i    ,
                input  logic                                     reset_i      ,

                //**************************************************
                // Wishbone classic slave
                //**************************************************

                input  logic                                     wb_cyc_i     ,
                input  logic                                     wb_stb_i     ,
                input  logic                                     wb_we_i      ,
                input  logic [safe_domain_pkg::WB_ADR_W-1:0]     wb_adr_i     ,
                input  logic [safe_domain_pkg::WB_DATA_W-1:0]    wb_dat_i     ,
                output logic [safe_domain_pkg::WB_DATA_W-1:0]    wb_dat_o     ,
                output logic                                     wb_ack_o     ,

                //**************************************************
                // SoC side
                //**************************************************

                input  logic [N_PADS-1:0]                        gpio_out_i   ,
                input  logic [N_PADS-1:0]                        gpio_dir_i   ,
                output logic [N_PADS-1:0]                        gpio_in_o    ,
                input  logic [N_PADS-1:0]                        periph_out_i ,
                input  logic [N_PADS-1:0]                        periph_oe_i  ,
                output logic [N_PADS-1:0]                        periph_in_o  ,

                //**************************************************
                // Pad frame side
                //**************************************************

                input  logic [N_PADS-1:0]                        pad_in_i     ,
                output logic [N_PADS-1:0]                        pad_out_o    ,
                output logic [N_PADS-1:0]                        pad_oe_o     ,
                output logic [N_PADS-1:0][safe_domain_pkg::PAD_CFG_W-1:0] pad_cfg_o
        );

        // Selector per pad, register block to mux
        safe_domain_pkg::pad_mux_e [N_PADS-1:0] s_pad_mux_sel;

        // Register block on the bus
        pad_cfg_regs
        #(
                .N_PADS        ( N_PADS        )
        )
        i_pad_cfg_regs
        (
                .ref_clk_i     ( ref_clk_i     ),
                .reset_i       ( reset_i       ),
                .wb_cyc_i      ( wb_cyc_i      ),
                .wb_stb_i      ( wb_stb_i      ),
                .wb_we_i       ( wb_we_i       ),
                .wb_adr_i      ( wb_adr_i      ),
                .wb_dat_i      ( wb_dat_i      ),
                .wb_dat_o      ( wb_dat_o      ),
                .wb_ack_o      ( wb_ack_o      ),
                .pad_mux_sel_o ( s_pad_mux_sel ),
                .pad_cfg_o     ( pad_cfg_o     )
        );

        // Pad routing and GPIO input sampling
        pad_mux
        #(
                .N_PADS        ( N_PADS        )
        )
        i_pad_mux
        (
                .ref_clk_i     ( ref_clk_i     ),
                .reset_i       ( reset_i       ),
                .pad_mux_sel_i ( s_pad_mux_sel ),
                .gpio_out_i    ( gpio_out_i    ),
                .gpio_dir_i    ( gpio_dir_i    ),
                .periph_out_i  ( periph_out_i  ),
                .periph_oe_i   ( periph_oe_i   ),
                .periph_in_o   ( periph_in_o   ),
                .gpio_in_o     ( gpio_in_o     ),
                .pad_in_i      ( pad_in_i      ),
                .pad_out_o     ( pad_out_o     ),
                .pad_oe_o      ( pad_oe_o      )
        );

endmodule

/* pad_ctrl/pad_cfg_regs.sv */
// Wishbone classic slave holding the mux selector and electrical config of each pad

`timescale 1ns/100ps

module pad_cfg_regs
        #(
                parameter int unsigned N_PADS = 8
        )
        (
                input  logic                                     ref_clk_i     ,
                input  logic                                     reset_i       ,

                //**************************************************
                // Wishbone classic slave
                //**************************************************

                input  logic                                     wb_cyc_i      ,
                input  logic                                     wb_stb_i      ,
                input  logic                                     wb_we_i       ,
                input  logic [safe_domain_pkg::WB_ADR_W-1:0]     wb_adr_i      ,
                input  logic [safe_domain_pkg::WB_DATA_W-1:0]    wb_dat_i      ,
                output logic [safe_domain_pkg::WB_DATA_W-1:0]    wb_dat_o      ,
                output logic                                     wb_ack_o      ,

                //**************************************************
                // Pad settings
                //**************************************************

                output safe_domain_pkg::pad_mux_e [N_PADS-1:0]   pad_mux_sel_o ,
                output logic [N_PADS-1:0][safe_domain_pkg::PAD_CFG_W-1:0] pad_cfg_o
        );

        // Index bits needed to address N_PADS registers
        localparam int unsigned IDX_W = (N_PADS > 1) ? $clog2(N_PADS) : 1;

        // Stored pad fields, reserved bits are not kept
        safe_domain_pkg::pad_mux_e [N_PADS-1:0]                mux_q;
        logic [N_PADS-1:0][safe_domain_pkg::PAD_CFG_W-1:0]     cfg_q;

        // Bus side state
        logic                                                  ack_q;
        logic [safe_domain_pkg::WB_DATA_W-1:0]                 rdata_q;

        // Address decode
        logic                                                  req;
        logic                                                  in_range;
        logic [IDX_W-1:0]                                      reg_idx;

        // Write data split into fields, read data assembled from fields
        safe_domain_pkg::pad_reg_u                             wr_word;
        safe_domain_pkg::pad_reg_u                             rd_word;

        //**************************************************
        // Request and address decode
        //**************************************************

        // New access only when the previous one was not just acked
        assign req      = wb_cyc_i & wb_stb_i & ~ack_q;

        assign reg_idx  = wb_adr_i[IDX_W-1:0];
        assign in_range = (32'(wb_adr_i) < N_PADS);

        assign wr_word.raw = wb_dat_i;

        // Selected register seen through the union, reserved bits stay zero
        always_comb
        begin
                rd_word.raw = '0;
                if (in_range)
                begin
                        rd_word.fields.mux = mux_q[reg_idx];
                        rd_word.fields.cfg = cfg_q[reg_idx];
                end
        end

        //**************************************************
        // Pad registers
        //**************************************************

        always_ff @(posedge ref_clk_i)
        begin
                if (reset_i)
                begin
                        for (int p = 0; p < N_PADS; p++)
                        begin
                                mux_q[p] <= safe_domain_pkg::PAD_GPIO;
                                cfg_q[p] <= '0;
                        end
                end
                else if (req && wb_we_i && in_range)
                begin
                        // Out of range writes are dropped
                        mux_q[reg_idx] <= wr_word.fields.mux;
                        cfg_q[reg_idx] <= wr_word.fields.cfg;
                end
        end

        //**************************************************
        // Acknowledge and read data
        //**************************************************

        always_ff @(posedge ref_clk_i)
        begin
                if (reset_i)
                begin
                        ack_q   <= 1'b0;
                        rdata_q <= '0;
                end
                else
                begin
                        // Single cycle ack, never two in a row
                        ack_q <= req;
                        if (req)
                        begin
                                rdata_q <= rd_word.raw;
                        end
                end
        end

        assign wb_ack_o = ack_q;
        assign wb_dat_o = rdata_q;

        // Settings go straight from the registers
        assign pad_mux_sel_o = mux_q;
        assign pad_cfg_o     = cfg_q;

endmodule

/* pad_ctrl/pad_mux.sv */
// Per-pad output and enable selection, peripheral input gating and GPIO input synchronizer

`timescale 1ns/100ps

module pad_mux
        #(
                parameter int unsigned N_PADS = 8
        )
        (
                input  logic                                   ref_clk_i     ,
                input  logic                                   reset_i       ,

                // Selector per pad from the register block
                input  safe_domain_pkg::pad_mux_e [N_PADS-1:0] pad_mux_sel_i ,

                //**************************************************
                // SoC side
                //**************************************************

                input  logic [N_PADS-1:0]                      gpio_out_i    ,
                input  logic [N_PADS-1:0]                      gpio_dir_i    ,
                input  logic [N_PADS-1:0]                      periph_out_i  ,
                input  logic [N_PADS-1:0]                      periph_oe_i   ,
                output logic [N_PADS-1:0]                      periph_in_o   ,
                output logic [N_PADS-1:0]                      gpio_in_o     ,

                //**************************************************
                // Pad frame side
                //**************************************************

                input  logic [N_PADS-1:0]                      pad_in_i      ,
                output logic [N_PADS-1:0]                      pad_out_o     ,
                output logic [N_PADS-1:0]                      pad_oe_o
        );

        // Two flop chain for pad inputs going to GPIO
        logic [N_PADS-1:0] sync_q1;
        logic [N_PADS-1:0] sync_q2;

        //**************************************************
        // Routing
        //**************************************************

        always_comb
        begin
                for (int p = 0; p < N_PADS; p++)
                begin
                        // Parked unless a valid owner is selected
                        pad_out_o[p]   = 1'b0;
                        pad_oe_o[p]    = 1'b0;
                        periph_in_o[p] = 1'b0;

                        case (pad_mux_sel_i[p])
                                safe_domain_pkg::PAD_GPIO:
                                begin
                                        pad_out_o[p] = gpio_out_i[p];
                                        pad_oe_o[p]  = gpio_dir_i[p];
                                end

                                safe_domain_pkg::PAD_ALT:
                                begin
                                        pad_out_o[p]   = periph_out_i[p];
                                        pad_oe_o[p]    = periph_oe_i[p];
                                        // Peripheral only sees the pad it owns
                                        periph_in_o[p] = pad_in_i[p];
                                end

                                default:
                                begin
                                        pad_out_o[p]   = 1'b0;
                                        pad_oe_o[p]    = 1'b0;
                                        periph_in_o[p] = 1'b0;
                                end
                        endcase
                end
        end

        //**************************************************
        // GPIO input synchronizer
        //**************************************************

        // Every pad is sampled, whatever its selector
        always_ff @(posedge ref_clk_i)
        begin
                if (reset_i)
                begin
                        sync_q1 <= '0;
                        sync_q2 <= '0;
                end
                else
                begin
                        sync_q1 <= pad_in_i;
                        sync_q2 <= sync_q1;
                end
        end

        assign gpio_in_o = sync_q2;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the pad block testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir
BIN=sim_safe_domain

rm -rf "$OBJ"
rm -f "$LOG"

verilator --binary --timing \
        --top-module tb_safe_domain \
        -f safe_domain.f \
        -Mdir "$OBJ" \
        -o "$BIN"

"./$OBJ/$BIN" > "$LOG" 2>&1
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"
then
        echo "Simulation reported failure, see $LOG"
        exit 1
fi

if ! grep -qF "*** TEST PASSED ***" "$LOG"
then
        echo "Simulation ended without a result, see $LOG"
        exit 1
fi

exit 0

/* safe_domain.f */
common/safe_domain_pkg.sv
pad_ctrl/pad_cfg_regs.sv
pad_ctrl/pad_mux.sv
hdl/safe_domain.sv
bench/tb_safe_domain.sv
